//--- design/acc_macros.svh
`ifndef ACC_MACROS_SVH
`define ACC_MACROS_SVH

// Output lanes of the systolic array
`define ACC_LANES 4

// Rows per tile, at least 2 so a row is written before the next tile reads it
`define TILE_ROWS 4

// Data widths
`define IN_DATA_W 8
`define ACC_DATA_W 16

// Bank geometry
`define ACC_ADDR_W 6
`define ACC_DEPTH (1 << `ACC_ADDR_W)

// Tile count
`define TILE_CNT_W 8

`endif

//--- design/acc_pkg.sv
`include "acc_macros.svh"

package acc_pkg;

    // One value from a lane of the array
    typedef logic [`IN_DATA_W-1:0] lane_data_t;

    // Accumulated partial sum, unsigned and wrapping
    typedef logic [`ACC_DATA_W-1:0] acc_data_t;

    // Bank row address
    typedef logic [`ACC_ADDR_W-1:0] acc_addr_t;

    // Tiles per block
    typedef logic [`TILE_CNT_W-1:0] tile_cnt_t;

    // Row index within a tile
    typedef logic [$clog2(`TILE_ROWS)-1:0] row_cnt_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_RUN
    } dec_state_t;

endpackage

//--- design/acc_if.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

////////////////////////////////////////////////////////////
// Per-lane write control, decode to execute
////////////////////////////////////////////////////////////

interface acc_wr_if;

    import acc_pkg::*;

    logic      [`ACC_LANES-1:0] wr_valid;
    acc_addr_t [`ACC_LANES-1:0] wr_addr;
    logic      [`ACC_LANES-1:0] wr_first;
    logic      [`ACC_LANES-1:0] wr_last;
    logic      [`ACC_LANES-1:0] wr_bank;

    modport master (output wr_valid, wr_addr, wr_first, wr_last, wr_bank);
    modport slave  (input  wr_valid, wr_addr, wr_first, wr_last, wr_bank);

endinterface

////////////////////////////////////////////////////////////
// Host read port, result to execute
////////////////////////////////////////////////////////////

interface acc_rd_if;

    import acc_pkg::*;

    logic                       rd_en;
    acc_addr_t                  rd_addr;
    acc_data_t [`ACC_LANES-1:0] ping_data;
    acc_data_t [`ACC_LANES-1:0] pong_data;

    modport master (output rd_en, rd_addr, input  ping_data, pong_data);
    modport slave  (input  rd_en, rd_addr, output ping_data, pong_data);

endinterface

//--- design/acc_bank_ram.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_bank_ram #(
    parameter int DEPTH = `ACC_DEPTH
) (
    input  logic               clk,
    input  logic               we,
    input  acc_pkg::acc_addr_t waddr,
    input  acc_pkg::acc_data_t wdata,
    input  acc_pkg::acc_addr_t ra_addr,
    output acc_pkg::acc_data_t ra_data,
    input  acc_pkg::acc_addr_t rb_addr,
    output acc_pkg::acc_data_t rb_data
);

    import acc_pkg::*;

    acc_data_t mem [DEPTH];

    // Both read ports return the value held before a same-edge write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        ra_data <= mem[ra_addr];
        rb_data <= mem[rb_addr];
    end

endmodule

//--- design/acc_decode.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_decode (
    input  logic               clk,
    input  logic               resetn,
    input  logic               wdata_available,
    input  acc_pkg::tile_cnt_t k_tiles,
    input  acc_pkg::acc_addr_t start_addr,
    input  logic               buffer_select,
    acc_wr_if.master           wr
);

    import acc_pkg::*;

    dec_state_t state;
    row_cnt_t   row_cnt;
    tile_cnt_t  tile_cnt;

    // Block parameters captured on the first beat
    acc_addr_t  start_lat;
    tile_cnt_t  k_lat;
    logic       bank_lat;

    // Lane 0 control
    acc_addr_t  start_sel;
    tile_cnt_t  k_sel;
    logic       bank0;
    logic       row_end;
    logic       tile_end;
    logic       last0;
    logic       first0;
    acc_addr_t  addr0;

    // Skew stages for lanes 1 and up
    logic      [`ACC_LANES-2:0] valid_q;
    acc_addr_t [`ACC_LANES-2:0] addr_q;
    logic      [`ACC_LANES-2:0] first_q;
    logic      [`ACC_LANES-2:0] last_q;
    logic      [`ACC_LANES-2:0] bank_q;

    ////////////////////////////////////////////////////////////
    // Block sequencer
    ////////////////////////////////////////////////////////////

    // On the first beat the live inputs stand in for the latched copies
    assign start_sel = (state == DEC_IDLE) ? start_addr : start_lat;
    assign k_sel     = (state == DEC_IDLE) ? k_tiles : k_lat;
    assign bank0     = (state == DEC_IDLE) ? buffer_select : bank_lat;

    assign row_end  = (row_cnt == row_cnt_t'(`TILE_ROWS - 1));
    assign tile_end = (tile_cnt == k_sel - tile_cnt_t'(1));
    assign last0    = row_end && tile_end;
    assign first0   = (tile_cnt == '0);
    assign addr0    = start_sel + acc_addr_t'(row_cnt);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= DEC_IDLE;
            row_cnt  <= '0;
            tile_cnt <= '0;
        end else if (wdata_available) begin
            // Back to idle after the final row so the next block can follow directly
            state <= last0 ? DEC_IDLE : DEC_RUN;
            if (row_end) begin
                row_cnt  <= '0;
                tile_cnt <= tile_end ? '0 : tile_cnt + tile_cnt_t'(1);
            end else begin
                row_cnt <= row_cnt + row_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DEC_IDLE && wdata_available) begin
            start_lat <= start_addr;
            k_lat     <= k_tiles;
            bank_lat  <= buffer_select;
        end
    end

    ////////////////////////////////////////////////////////////
    // Skew line
    ////////////////////////////////////////////////////////////

    // Lane i sees the lane 0 control i cycles late
    assign wr.wr_valid = {valid_q, wdata_available};
    assign wr.wr_addr  = {addr_q, addr0};
    assign wr.wr_first = {first_q, first0};
    assign wr.wr_last  = {last_q, last0};
    assign wr.wr_bank  = {bank_q, bank0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
        end else begin
            valid_q <= wr.wr_valid[`ACC_LANES-2:0];
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= wr.wr_addr[`ACC_LANES-2:0];
        first_q <= wr.wr_first[`ACC_LANES-2:0];
        last_q  <= wr.wr_last[`ACC_LANES-2:0];
        bank_q  <= wr.wr_bank[`ACC_LANES-2:0];
    end

endmodule

//--- design/acc_execute.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_execute (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  acc_pkg::lane_data_t [`ACC_LANES-1:0] wdata,
    acc_wr_if.slave                              wr,
    acc_rd_if.slave                              rd
);

    import acc_pkg::*;

    acc_addr_t host_addr;
    acc_addr_t host_addr_q;

    // Port B stays on the last host address between reads
    assign host_addr = rd.rd_en ? rd.rd_addr : host_addr_q;

    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            host_addr_q <= rd.rd_addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane read-add-write pipelines
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `ACC_LANES; i++) begin : g_lane
        logic       v_q;
        logic       first_q;
        logic       bank_q;
        acc_addr_t  addr_q;
        lane_data_t data_q;
        acc_data_t  ping_acc;
        acc_data_t  pong_acc;
        acc_data_t  ping_host;
        acc_data_t  pong_host;
        acc_data_t  base;
        acc_data_t  sum;

        always_ff @(posedge clk) begin
            if (!resetn) begin
                v_q <= 1'b0;
            end else begin
                v_q <= wr.wr_valid[i];
            end
        end

        // Arrival cycle, port A reads both banks at the write address
        always_ff @(posedge clk) begin
            addr_q  <= wr.wr_addr[i];
            first_q <= wr.wr_first[i];
            bank_q  <= wr.wr_bank[i];
            data_q  <= wdata[i];
        end

        // First tile starts from zero
        assign base = first_q ? '0 : (bank_q ? ping_acc : pong_acc);
        assign sum  = base + acc_data_t'(data_q);

        acc_bank_ram #(
            .DEPTH(`ACC_DEPTH)
        ) i_ping (
            .clk    (clk),
            .we     (v_q & bank_q),
            .waddr  (addr_q),
            .wdata  (sum),
            .ra_addr(wr.wr_addr[i]),
            .ra_data(ping_acc),
            .rb_addr(host_addr),
            .rb_data(ping_host)
        );

        acc_bank_ram #(
            .DEPTH(`ACC_DEPTH)
        ) i_pong (
            .clk    (clk),
            .we     (v_q & ~bank_q),
            .waddr  (addr_q),
            .wdata  (sum),
            .ra_addr(wr.wr_addr[i]),
            .ra_data(pong_acc),
            .rb_addr(host_addr),
            .rb_data(pong_host)
        );

        assign rd.ping_data[i] = ping_host;
        assign rd.pong_data[i] = pong_host;
    end

endmodule

//--- design/acc_result.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_result (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                rd_en,
    input  acc_pkg::acc_addr_t                  rd_addr,
    input  logic                                rd_bank,
    output acc_pkg::acc_data_t [`ACC_LANES-1:0] rd_data,
    output logic                                rd_valid,
    input  logic                                last_write,
    output logic                                block_done,
    acc_rd_if.master                            rd
);

    logic       bank_q;
    logic [2:0] done_pipe;

    ////////////////////////////////////////////////////////////
    // Host read-out
    ////////////////////////////////////////////////////////////

    assign rd.rd_en   = rd_en;
    assign rd.rd_addr = rd_addr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= rd_bank;
    end

    // Bank select 1 is ping
    assign rd_data = bank_q ? rd.ping_data : rd.pong_data;

    ////////////////////////////////////////////////////////////
    // Block completion
    ////////////////////////////////////////////////////////////

    // Last lane element is written two edges after it arrives, strobe one edge later
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_pipe <= '0;
        end else begin
            done_pipe <= {done_pipe[1:0], last_write};
        end
    end

    assign block_done = done_pipe[2];

endmodule

//--- design/accumulator_top.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module accumulator_top (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 wdata_available,
    input  acc_pkg::lane_data_t [`ACC_LANES-1:0] wdata,
    input  acc_pkg::tile_cnt_t                   k_tiles,
    input  acc_pkg::acc_addr_t                   start_addr,
    input  logic                                 buffer_select,
    input  logic                                 rd_en,
    input  acc_pkg::acc_addr_t                   rd_addr,
    input  logic                                 rd_bank,
    output acc_pkg::acc_data_t [`ACC_LANES-1:0]  rd_data,
    output logic                                 rd_valid,
    output logic                                 block_done
);

    acc_wr_if wr_if ();
    acc_rd_if rd_if ();

    // Final row on the last lane closes the block
    logic last_write;

    assign last_write = wr_if.wr_valid[`ACC_LANES-1] & wr_if.wr_last[`ACC_LANES-1];

    ////////////////////////////////////////////////////////////
    // Decode, execute, result
    ////////////////////////////////////////////////////////////

    acc_decode i_acc_decode (
        .clk            (clk),
        .resetn         (resetn),
        .wdata_available(wdata_available),
        .k_tiles        (k_tiles),
        .start_addr     (start_addr),
        .buffer_select  (buffer_select),
        .wr             (wr_if.master)
    );

    acc_execute i_acc_execute (
        .clk   (clk),
        .resetn(resetn),
        .wdata (wdata),
        .wr    (wr_if.slave),
        .rd    (rd_if.slave)
    );

    acc_result i_acc_result (
        .clk       (clk),
        .resetn    (resetn),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_bank   (rd_bank),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .last_write(last_write),
        .block_done(block_done),
        .rd        (rd_if.master)
    );

endmodule

//--- dv/tb_accumulator.sv
`timescale 1ns/1ps
`include "acc_macros.svh"

module tb_accumulator;

    import acc_pkg::*;

    // Budget for 8 blocks over 12 tiles and 6 reads over 8 tiles of rows plus idle stretches
    localparam int BLK_OVERHEAD = `ACC_LANES + 2;
    localparam int BLOCK_CYCLES = 12 * `TILE_ROWS + 8 * BLK_OVERHEAD;
    localparam int READ_CYCLES  = 8 * `TILE_ROWS + 6 * 2;
    localparam int IDLE_CYCLES  = 5 + 8 + 8;
    localparam int CYCLE_LIMIT  = 2 * (BLOCK_CYCLES + READ_CYCLES + IDLE_CYCLES);

    logic                       clk;
    logic                       resetn;
    logic                       wdata_available;
    lane_data_t [`ACC_LANES-1:0] wdata;
    tile_cnt_t                  k_tiles;
    acc_addr_t                  start_addr;
    logic                       buffer_select;
    logic                       rd_en;
    acc_addr_t                  rd_addr;
    logic                       rd_bank;
    acc_data_t [`ACC_LANES-1:0] rd_data;
    logic                       rd_valid;
    logic                       block_done;

    // Reference copy of both banks
    acc_data_t ping_model [`ACC_DEPTH][`ACC_LANES];
    acc_data_t pong_model [`ACC_DEPTH][`ACC_LANES];

    logic [31:0] lfsr_state = 32'h1c9f;
    int          cycle_count = 0;

    accumulator_top i_accumulator_top (
        .clk            (clk),
        .resetn         (resetn),
        .wdata_available(wdata_available),
        .wdata          (wdata),
        .k_tiles        (k_tiles),
        .start_addr     (start_addr),
        .buffer_select  (buffer_select),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_bank        (rd_bank),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .block_done     (block_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic acc_data_t model_read(logic bank, acc_addr_t addr, int lane);
        return bank ? ping_model[addr][lane] : pong_model[addr][lane];
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic idle_cycles(int n);
        for (int c = 0; c < n; c++) begin
            check_value("rd_valid", 32'(rd_valid), 32'd0);
            check_value("block_done", 32'(block_done), 32'd0);
            @(posedge clk);
            #1;
        end
    endtask

    // Drives one block with skewed lanes and checks the done strobe edge by edge
    task automatic run_block(int k, acc_addr_t start, logic bank);
        lane_data_t blk [`ACC_DEPTH][`ACC_LANES];
        int         len;
        int         done_edge;
        int         e;
        int         tile;
        acc_addr_t  addr;
        acc_data_t  base;
        len = k * `TILE_ROWS;
        done_edge = len - 1 + `ACC_LANES + 1;
        for (e = 0; e < len; e++) begin
            for (int l = 0; l < `ACC_LANES; l++) begin
                blk[e][l] = lane_data_t'(lfsr_bits(`IN_DATA_W));
            end
        end
        for (int t = 0; t <= done_edge + 1; t++) begin
            wdata_available = (t < len);
            k_tiles         = (t == 0) ? tile_cnt_t'(k) : '0;
            start_addr      = (t == 0) ? start : '0;
            buffer_select   = (t == 0) ? bank : 1'b0;
            for (int l = 0; l < `ACC_LANES; l++) begin
                e = t - l;
                wdata[l] = (e >= 0 && e < len) ? blk[e][l] : '0;
            end
            @(posedge clk);
            #1;
            // Edge t samples cycle t
            check_value("block_done", 32'(block_done), 32'(t == done_edge));
        end
        for (e = 0; e < len; e++) begin
            tile = e / `TILE_ROWS;
            addr = start + acc_addr_t'(e % `TILE_ROWS);
            for (int l = 0; l < `ACC_LANES; l++) begin
                base = (tile == 0) ? '0 : model_read(bank, addr, l);
                if (bank) begin
                    ping_model[addr][l] = base + acc_data_t'(blk[e][l]);
                end else begin
                    pong_model[addr][l] = base + acc_data_t'(blk[e][l]);
                end
            end
        end
    endtask

    // One read per cycle with its data checked on the following edge
    task automatic read_rows(logic bank, acc_addr_t first, int count);
        acc_addr_t row;
        for (int n = 0; n <= count + 1; n++) begin
            if (n >= 1 && n <= count) begin
                row = first + acc_addr_t'(n - 1);
                check_value("rd_valid", 32'(rd_valid), 32'd1);
                for (int l = 0; l < `ACC_LANES; l++) begin
                    check_value($sformatf("rd_data[%0d] at row 0x%0h", l, row),
                                32'(rd_data[l]), 32'(model_read(bank, row, l)));
                end
            end else if (n == count + 1) begin
                check_value("rd_valid", 32'(rd_valid), 32'd0);
            end
            if (n < count) begin
                rd_en   = 1'b1;
                rd_addr = first + acc_addr_t'(n);
                rd_bank = bank;
            end else begin
                rd_en = 1'b0;
            end
            if (n == 0) begin
                // No response before the first request is sampled
                #1;
                check_value("rd_valid", 32'(rd_valid), 32'd0);
            end
            if (n <= count) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        idle_cycles(8);
    endtask

    task automatic test_single_tile();
        run_block(1, 6'd0, 1'b1);
        read_rows(1'b1, 6'd0, `TILE_ROWS);
    endtask

    // Neighbours in pong are filled first so the read shows they survive
    task automatic test_multi_tile();
        run_block(1, acc_addr_t'(8 - `TILE_ROWS), 1'b0);
        run_block(1, acc_addr_t'(8 + `TILE_ROWS), 1'b0);
        run_block(3, 6'd8, 1'b0);
        read_rows(1'b0, acc_addr_t'(8 - `TILE_ROWS), 3 * `TILE_ROWS);
    endtask

    task automatic test_ping_pong();
        run_block(2, 6'd16, 1'b0);
        fork
            run_block(1, 6'd16, 1'b1);
            read_rows(1'b0, 6'd16, `TILE_ROWS);
        join
        read_rows(1'b1, 6'd16, `TILE_ROWS);
        // Pong still holds its own block after the ping fill
        read_rows(1'b0, 6'd16, `TILE_ROWS);
    endtask

    task automatic test_done_timing();
        run_block(2, 6'd32, 1'b1);
        idle_cycles(8);
    endtask

    task automatic test_overwrite();
        run_block(1, 6'd0, 1'b1);
        read_rows(1'b1, 6'd0, `TILE_ROWS);
    endtask

    initial begin
        resetn          = 1'b0;
        wdata_available = 1'b0;
        wdata           = '0;
        k_tiles         = '0;
        start_addr      = '0;
        buffer_select   = 1'b0;
        rd_en           = 1'b0;
        rd_addr         = '0;
        rd_bank         = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        test_reset_idle();
        test_single_tile();
        test_multi_tile();
        test_ping_pong();
        test_done_timing();
        test_overwrite();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/acc_pkg.sv
design/acc_if.sv
design/acc_bank_ram.sv
design/acc_decode.sv
design/acc_execute.sv
design/acc_result.sv
design/accumulator_top.sv
dv/tb_accumulator.sv

//--- Makefile
# Verilator build and run for the accumulator testbench

VERILATOR  ?= verilator
TOP        ?= tb_accumulator
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
